/* bench/glb_clk_gen.sv */
`timescale 1ns/1ps

module glb_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 5
) (
    input  logic rst_req_i,
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held for RST_CYCLES rising edges, at start and on each request
    initial begin
        rst_n = 1'b0;
        forever begin
            repeat (RST_CYCLES) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            @(posedge rst_req_i);
            @(negedge clk);
            rst_n = 1'b0;
        end
    end

endmodule

/* bench/glb_tb.sv */
`timescale 1ns/1ps

module glb_tb;
    import glb_geom_pkg::*;
    import glb_port_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int HS_LIMIT   = 20;
    // Port 0 owns banks 0..3 at par 2, port 1 owns banks 4..7 at par 4
    localparam logic [CFG_FLAG_W-1:0] FLAGS_ALL   = {8'hF0, 8'h0F, 8'hF0, 8'h0F};
    localparam logic [CFG_FLAG_W-1:0] FLAGS_PORT0 = {8'h00, 8'h0F, 8'h00, 8'h0F};
    localparam logic [CFG_PAR_W-1:0]  PARS_ALL    = {3'd4, 3'd2, 3'd4, 3'd2};
    localparam logic [31:0] LCG_SEED = 32'd55361;

    // Watchdog budget from beats per test and a generous cycle count per beat
    localparam int RT_OPS      = 40;
    localparam int EMPTY_OPS   = 6;
    localparam int FULL_OPS    = 38;
    localparam int BP_OPS      = 10;
    localparam int UNALLOC_OPS = 8;
    localparam int TOTAL_OPS   = RT_OPS + EMPTY_OPS + FULL_OPS + BP_OPS + UNALLOC_OPS;
    localparam int WATCHDOG_NS = (TOTAL_OPS * 8 + 3 * 12 + 200) * CLK_PERIOD;

    logic                             clk;
    logic                             rst_n;
    logic                             rst_req;
    logic [CFG_FLAG_W-1:0]            cfg_bank_flag_i;
    logic [CFG_PAR_W-1:0]             cfg_par_i;
    logic [BEAT_W*NUM_WRPORT-1:0]     wr_dat_i;
    logic [ADDR_WIDTH*NUM_WRPORT-1:0] wr_addr_i;
    logic [NUM_WRPORT-1:0]            wr_vld_i;
    logic [NUM_WRPORT-1:0]            wr_rdy_o;
    logic [ADDR_WIDTH*NUM_RDPORT-1:0] rd_addr_i;
    logic [NUM_RDPORT-1:0]            rd_addr_vld_i;
    logic [NUM_RDPORT-1:0]            rd_addr_rdy_o;
    logic [BEAT_W*NUM_RDPORT-1:0]     rd_dat_o;
    logic [NUM_RDPORT-1:0]            rd_dat_vld_o;
    logic [NUM_RDPORT-1:0]            rd_dat_rdy_i;

    logic [31:0]       lcg_state;
    logic [BEAT_W-1:0] model_mem [NUM_WRPORT][256];
    int                mismatch_cnt;
    int                fail_cnt;

    glb_clk_gen #(
        .PERIOD_NS  (CLK_PERIOD),
        .RST_CYCLES (5)
    ) clk_gen_inst (
        .rst_req_i (rst_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    glb glb_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_bank_flag_i (cfg_bank_flag_i),
        .cfg_par_i       (cfg_par_i),
        .wr_dat_i        (wr_dat_i),
        .wr_addr_i       (wr_addr_i),
        .wr_vld_i        (wr_vld_i),
        .wr_rdy_o        (wr_rdy_o),
        .rd_addr_i       (rd_addr_i),
        .rd_addr_vld_i   (rd_addr_vld_i),
        .rd_addr_rdy_o   (rd_addr_rdy_o),
        .rd_dat_o        (rd_dat_o),
        .rd_dat_vld_o    (rd_dat_vld_o),
        .rd_dat_rdy_i    (rd_dat_rdy_i)
    );

    // ======================================================================
    // Reference model and helpers
    // ======================================================================
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic [BEAT_W-1:0] rand_beat();
        logic [BEAT_W-1:0] beat;
        beat = '0;
        for (int k = 0; k < MAXPAR; k++) begin
            beat[k*SRAM_WIDTH +: SRAM_WIDTH] = lcg_next();
        end
        return beat;
    endfunction

    function automatic int port_par(input int port);
        return (port == 0) ? 2 : 4;
    endfunction

    // Each port owns four banks and spreads a beat over par of them
    function automatic int port_space(input int port);
        return SRAM_WORD * 4 / port_par(port);
    endfunction

    function automatic logic [BEAT_W-1:0] expected_beat(input int port, input int addr);
        logic [BEAT_W-1:0] beat;
        logic [BEAT_W-1:0] out;
        beat = model_mem[port][addr % port_space(port)];
        out  = '0;
        for (int k = 0; k < port_par(port); k++) begin
            out[k*SRAM_WIDTH +: SRAM_WIDTH] = beat[k*SRAM_WIDTH +: SRAM_WIDTH];
        end
        return out;
    endfunction

    task automatic compare(input string label, input logic [BEAT_W-1:0] expected,
                           input logic [BEAT_W-1:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s: expected %h, actual %h", label, expected, actual);
            mismatch_cnt++;
        end
    endtask

    task automatic apply_reset(input logic [CFG_FLAG_W-1:0] flags,
                               input logic [CFG_PAR_W-1:0] pars);
        @(negedge clk);
        rst_req = 1'b1;
        @(negedge rst_n);
        cfg_bank_flag_i = flags;
        cfg_par_i       = pars;
        rst_req         = 1'b0;
        @(posedge rst_n);
    endtask

    task automatic write_line(input int port, input int addr, input logic [BEAT_W-1:0] data);
        int waited;
        @(negedge clk);
        wr_addr_i[port*ADDR_WIDTH +: ADDR_WIDTH] = ADDR_WIDTH'(addr);
        wr_dat_i[port*BEAT_W +: BEAT_W]          = data;
        wr_vld_i[port]                           = 1'b1;
        waited = 0;
        #1;
        while (!wr_rdy_o[port] && waited < HS_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (wr_rdy_o[port]) begin
            @(posedge clk);
            model_mem[port][addr % port_space(port)] = data;
        end else begin
            $display("timeout: write port %0d never accepted line %0d", port, addr);
            fail_cnt++;
        end
        @(negedge clk);
        wr_vld_i[port] = 1'b0;
    endtask

    task automatic issue_read(input int port, input int addr);
        int waited;
        @(negedge clk);
        rd_addr_i[port*ADDR_WIDTH +: ADDR_WIDTH] = ADDR_WIDTH'(addr);
        rd_addr_vld_i[port]                      = 1'b1;
        waited = 0;
        #1;
        while (!rd_addr_rdy_o[port] && waited < HS_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (rd_addr_rdy_o[port]) begin
            @(posedge clk);
        end else begin
            $display("timeout: read port %0d never accepted line %0d", port, addr);
            fail_cnt++;
        end
        @(negedge clk);
        rd_addr_vld_i[port] = 1'b0;
    endtask

    task automatic wait_data(input int port, output bit got);
        int waited;
        waited = 0;
        #1;
        while (!rd_dat_vld_o[port] && waited < HS_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        got = rd_dat_vld_o[port];
        if (!got) begin
            $display("timeout: read port %0d returned no data", port);
            fail_cnt++;
        end
    endtask

    task automatic read_check(input int port, input int addr, input string label);
        bit got;
        issue_read(port, addr);
        wait_data(port, got);
        if (got) begin
            compare(label, expected_beat(port, addr), rd_dat_o[port*BEAT_W +: BEAT_W]);
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic test_reset_state();
        @(negedge clk);
        #1;
        compare("reset rd_addr_rdy", '0, BEAT_W'(rd_addr_rdy_o));
        compare("reset rd_dat_vld", '0, BEAT_W'(rd_dat_vld_o));
        compare("reset wr_rdy", BEAT_W'(2'b11), BEAT_W'(wr_rdy_o));
    endtask

    task automatic test_round_trip();
        for (int port = 0; port < NUM_WRPORT; port++) begin
            for (int a = 0; a < 10; a++) begin
                write_line(port, a, rand_beat());
            end
            for (int a = 0; a < 10; a++) begin
                read_check(port, a, $sformatf("round trip port %0d line %0d", port, a));
            end
        end
    endtask

    task automatic test_empty();
        @(negedge clk);
        rd_addr_i[0 +: ADDR_WIDTH] = 8'd10;
        repeat (3) begin
            #1;
            compare("empty line 10 before write", '0, BEAT_W'(rd_addr_rdy_o[0]));
            @(negedge clk);
        end
        write_line(0, 10, rand_beat());
        #1;
        compare("empty line 10 after write", BEAT_W'(1), BEAT_W'(rd_addr_rdy_o[0]));
        read_check(0, 10, "empty line 10 data");
    endtask

    task automatic test_full();
        apply_reset(FLAGS_ALL, PARS_ALL);
        for (int a = 0; a < 32; a++) begin
            write_line(0, a, rand_beat());
        end
        @(negedge clk);
        wr_addr_i[0 +: ADDR_WIDTH] = 8'd32;
        #1;
        compare("full at line 32", '0, BEAT_W'(wr_rdy_o[0]));
        read_check(0, 0, "full drain line 0");
        compare("full ready after drain", BEAT_W'(1), BEAT_W'(wr_rdy_o[0]));
        write_line(0, 32, rand_beat());
        read_check(0, 32, "full wrap line 32");
    endtask

    task automatic test_back_pressure();
        bit got;
        @(negedge clk);
        rd_dat_rdy_i[0] = 1'b0;
        issue_read(0, 5);
        wait_data(0, got);
        compare("back pressure line 5", expected_beat(0, 5), rd_dat_o[0 +: BEAT_W]);
        // Line 6 sits in the same banks, so it has to wait
        repeat (3) begin
            @(negedge clk);
            rd_addr_i[0 +: ADDR_WIDTH] = 8'd6;
            rd_addr_vld_i[0]           = 1'b1;
            #1;
            compare("back pressure vld held", BEAT_W'(1), BEAT_W'(rd_dat_vld_o[0]));
            compare("back pressure data held", expected_beat(0, 5), rd_dat_o[0 +: BEAT_W]);
            compare("back pressure addr stall", '0, BEAT_W'(rd_addr_rdy_o[0]));
        end
        @(negedge clk);
        rd_dat_rdy_i[0]  = 1'b1;
        rd_addr_vld_i[0] = 1'b0;
        @(negedge clk);
        #1;
        compare("back pressure data taken", '0, BEAT_W'(rd_dat_vld_o[0]));
        read_check(0, 6, "back pressure line 6");
    endtask

    task automatic test_unallocated();
        apply_reset(FLAGS_PORT0, PARS_ALL);
        @(negedge clk);
        wr_addr_i[ADDR_WIDTH +: ADDR_WIDTH] = 8'd0;
        rd_addr_i[ADDR_WIDTH +: ADDR_WIDTH] = 8'd0;
        wr_vld_i[1]                         = 1'b1;
        rd_addr_vld_i[1]                    = 1'b1;
        repeat (4) begin
            #1;
            compare("unallocated wr_rdy", '0, BEAT_W'(wr_rdy_o[1]));
            compare("unallocated rd_addr_rdy", '0, BEAT_W'(rd_addr_rdy_o[1]));
            compare("unallocated rd_dat_vld", '0, BEAT_W'(rd_dat_vld_o[1]));
            @(negedge clk);
        end
        wr_vld_i[1]      = 1'b0;
        rd_addr_vld_i[1] = 1'b0;
        write_line(0, 3, rand_beat());
        read_check(0, 3, "unallocated port 0 line 3");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        lcg_state       = LCG_SEED;
        mismatch_cnt    = 0;
        fail_cnt        = 0;
        rst_req         = 1'b0;
        cfg_bank_flag_i = FLAGS_ALL;
        cfg_par_i       = PARS_ALL;
        wr_dat_i        = '0;
        wr_addr_i       = '0;
        wr_vld_i        = '0;
        rd_addr_i       = '0;
        rd_addr_vld_i   = '0;
        rd_dat_rdy_i    = '1;
        @(posedge rst_n);
        test_reset_state();
        test_round_trip();
        test_empty();
        test_full();
        test_back_pressure();
        test_unallocated();
        $display("summary: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* glb.f */
rtl/glb_geom_pkg.sv
rtl/glb_port_pkg.sv
rtl/glb_ram_hs.sv
rtl/glb_port_map.sv
rtl/glb_bank_slice.sv
rtl/glb_wr_ctrl.sv
rtl/glb_rd_ctrl.sv
rtl/glb.sv
bench/glb_clk_gen.sv
bench/glb_tb.sv

/* rtl/glb.sv */
`timescale 1ns/1ps

module glb (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic [glb_port_pkg::CFG_FLAG_W-1:0]                          cfg_bank_flag_i,
    input  logic [glb_port_pkg::CFG_PAR_W-1:0]                           cfg_par_i,
    input  logic [glb_port_pkg::BEAT_W*glb_port_pkg::NUM_WRPORT-1:0]     wr_dat_i,
    input  logic [glb_port_pkg::ADDR_WIDTH*glb_port_pkg::NUM_WRPORT-1:0] wr_addr_i,
    input  logic [glb_port_pkg::NUM_WRPORT-1:0]                          wr_vld_i,
    output logic [glb_port_pkg::NUM_WRPORT-1:0]                          wr_rdy_o,
    input  logic [glb_port_pkg::ADDR_WIDTH*glb_port_pkg::NUM_RDPORT-1:0] rd_addr_i,
    input  logic [glb_port_pkg::NUM_RDPORT-1:0]                          rd_addr_vld_i,
    output logic [glb_port_pkg::NUM_RDPORT-1:0]                          rd_addr_rdy_o,
    output logic [glb_port_pkg::BEAT_W*glb_port_pkg::NUM_RDPORT-1:0]     rd_dat_o,
    output logic [glb_port_pkg::NUM_RDPORT-1:0]                          rd_dat_vld_o,
    input  logic [glb_port_pkg::NUM_RDPORT-1:0]                          rd_dat_rdy_i
);
    import glb_geom_pkg::*;
    import glb_port_pkg::*;

    logic [NUM_BANK*NUM_WRPORT-1:0]   wr_bank_en;
    logic [NUM_BANK*NUM_RDPORT-1:0]   rd_bank_en;
    logic [NUM_BANK-1:0]              arready_all;
    logic [NUM_BANK-1:0]              rvalid_all;
    logic [SRAM_WIDTH*NUM_BANK-1:0]   rdata_all;
    logic [ADDR_WIDTH*NUM_BANK-1:0]   wr_mark_all;
    logic [ADDR_WIDTH*NUM_BANK-1:0]   rd_mark_all;

    // ======================================================================
    // Banks
    // ======================================================================
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        glb_bank_slice #(
            .BANK_ID (b)
        ) u_slice (
            .clk             (clk),
            .rst_n           (rst_n),
            .cfg_bank_flag_i (cfg_bank_flag_i),
            .wr_bank_en_i    (wr_bank_en),
            .wr_addr_i       (wr_addr_i),
            .wr_dat_i        (wr_dat_i),
            .rd_bank_en_i    (rd_bank_en),
            .rd_addr_i       (rd_addr_i),
            .rd_dat_rdy_i    (rd_dat_rdy_i),
            .arready_o       (arready_all[b]),
            .rvalid_o        (rvalid_all[b]),
            .rdata_o         (rdata_all[b*SRAM_WIDTH +: SRAM_WIDTH]),
            .wr_mark_o       (wr_mark_all[b*ADDR_WIDTH +: ADDR_WIDTH]),
            .rd_mark_o       (rd_mark_all[b*ADDR_WIDTH +: ADDR_WIDTH])
        );
    end

    // ======================================================================
    // Port controllers
    // ======================================================================
    for (genvar p = 0; p < NUM_WRPORT; p++) begin : g_wr
        glb_wr_ctrl #(
            .PORT (p)
        ) u_wr (
            .cfg_bank_flag_i (cfg_bank_flag_i),
            .cfg_par_i       (cfg_par_i),
            .wr_addr_i       (wr_addr_i[p*ADDR_WIDTH +: ADDR_WIDTH]),
            .wr_vld_i        (wr_vld_i[p]),
            .wr_rdy_o        (wr_rdy_o[p]),
            .rd_mark_all_i   (rd_mark_all),
            .bank_en_o       (wr_bank_en[p*NUM_BANK +: NUM_BANK])
        );
    end

    for (genvar p = 0; p < NUM_RDPORT; p++) begin : g_rd
        glb_rd_ctrl #(
            .PORT (p)
        ) u_rd (
            .clk             (clk),
            .rst_n           (rst_n),
            .cfg_bank_flag_i (cfg_bank_flag_i),
            .cfg_par_i       (cfg_par_i),
            .rd_addr_i       (rd_addr_i[p*ADDR_WIDTH +: ADDR_WIDTH]),
            .rd_addr_vld_i   (rd_addr_vld_i[p]),
            .rd_addr_rdy_o   (rd_addr_rdy_o[p]),
            .wr_mark_all_i   (wr_mark_all),
            .arready_all_i   (arready_all),
            .rvalid_all_i    (rvalid_all),
            .rdata_all_i     (rdata_all),
            .bank_en_o       (rd_bank_en[p*NUM_BANK +: NUM_BANK]),
            .rd_dat_o        (rd_dat_o[p*BEAT_W +: BEAT_W]),
            .rd_dat_vld_o    (rd_dat_vld_o[p])
        );
    end

endmodule

/* rtl/glb_bank_slice.sv */
`timescale 1ns/1ps

module glb_bank_slice #(
    parameter int BANK_ID = 0
) (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  logic [glb_port_pkg::CFG_FLAG_W-1:0]                        cfg_bank_flag_i,
    input  logic [glb_geom_pkg::NUM_BANK*glb_port_pkg::NUM_WRPORT-1:0] wr_bank_en_i,
    input  logic [glb_port_pkg::ADDR_WIDTH*glb_port_pkg::NUM_WRPORT-1:0] wr_addr_i,
    input  logic [glb_port_pkg::BEAT_W*glb_port_pkg::NUM_WRPORT-1:0]   wr_dat_i,
    input  logic [glb_geom_pkg::NUM_BANK*glb_port_pkg::NUM_RDPORT-1:0] rd_bank_en_i,
    input  logic [glb_port_pkg::ADDR_WIDTH*glb_port_pkg::NUM_RDPORT-1:0] rd_addr_i,
    input  logic [glb_port_pkg::NUM_RDPORT-1:0]                        rd_dat_rdy_i,
    output logic                                                       arready_o,
    output logic                                                       rvalid_o,
    output logic [glb_geom_pkg::SRAM_WIDTH-1:0]                        rdata_o,
    output logic [glb_port_pkg::ADDR_WIDTH-1:0]                        wr_mark_o,
    output logic [glb_port_pkg::ADDR_WIDTH-1:0]                        rd_mark_o
);
    import glb_geom_pkg::*;
    import glb_port_pkg::*;

    logic [WRPORT_IDX_W-1:0] wsel;
    logic [RDPORT_IDX_W-1:0] rsel;
    logic                    wcov;
    logic                    rcov;
    logic [NUM_BANK-1:0]     wen;
    logic [NUM_BANK-1:0]     ren;
    logic [PAR_W-2:0]        woff;
    logic [ADDR_WIDTH-1:0]   waddr_full;
    logic [ADDR_WIDTH-1:0]   raddr_full;
    logic [SRAM_WIDTH-1:0]   wdata;
    logic                    wvalid;
    logic                    wready;
    logic                    arvalid;
    logic                    rready;

    // ======================================================================
    // Port selection, lowest covering port wins
    // ======================================================================
    always_comb begin
        wsel = '0;
        wcov = 1'b0;
        rsel = '0;
        rcov = 1'b0;
        for (int p = NUM_WRPORT - 1; p >= 0; p--) begin
            if (cfg_bank_flag_i[p*NUM_BANK + BANK_ID]) begin
                wsel = WRPORT_IDX_W'(p);
                wcov = 1'b1;
            end
        end
        for (int p = NUM_RDPORT - 1; p >= 0; p--) begin
            if (cfg_bank_flag_i[(NUM_WRPORT + p)*NUM_BANK + BANK_ID]) begin
                rsel = RDPORT_IDX_W'(p);
                rcov = 1'b1;
            end
        end
    end

    // ======================================================================
    // Write and read muxing
    // ======================================================================
    assign wen        = wr_bank_en_i[wsel*NUM_BANK +: NUM_BANK];
    assign waddr_full = wr_addr_i[wsel*ADDR_WIDTH +: ADDR_WIDTH];
    assign wvalid     = wcov & wen[BANK_ID];

    // Enabled banks below this one give the word offset in the beat
    always_comb begin
        woff = '0;
        for (int i = 0; i < BANK_ID; i++) begin
            woff = woff + (PAR_W-1)'(wen[i]);
        end
    end

    assign wdata      = wr_dat_i[wsel*BEAT_W + woff*SRAM_WIDTH +: SRAM_WIDTH];

    assign ren        = rd_bank_en_i[rsel*NUM_BANK +: NUM_BANK];
    assign raddr_full = rd_addr_i[rsel*ADDR_WIDTH +: ADDR_WIDTH];
    assign arvalid    = rcov & ren[BANK_ID];
    assign rready     = rd_dat_rdy_i[rsel];

    // Circular-buffer marks, last line plus one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_mark_o <= '0;
            rd_mark_o <= '0;
        end else begin
            if (wvalid && wready) begin
                wr_mark_o <= waddr_full + 1'b1;
            end
            if (arvalid && arready_o) begin
                rd_mark_o <= raddr_full + 1'b1;
            end
        end
    end

    glb_ram_hs u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .waddr_i   (waddr_full[ROW_W-1:0]),
        .wdata_i   (wdata),
        .arvalid_i (arvalid),
        .arready_o (arready_o),
        .araddr_i  (raddr_full[ROW_W-1:0]),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready),
        .rdata_o   (rdata_o)
    );

endmodule

/* rtl/glb_geom_pkg.sv */
package glb_geom_pkg;

    // ======================================================================
    // Bank and SRAM geometry
    // ======================================================================

    localparam int NUM_BANK   = 8;
    localparam int SRAM_WIDTH = 16;
    // Rows per bank, must stay a power of two
    localparam int SRAM_WORD  = 16;

    // Derived index widths
    localparam int ROW_W      = $clog2(SRAM_WORD);
    localparam int BANK_IDX_W = $clog2(NUM_BANK);
    localparam int BANK_CNT_W = BANK_IDX_W + 1;

endpackage

/* rtl/glb_port_map.sv */
`timescale 1ns/1ps

module glb_port_map #(
    parameter int FLAG_OFFSET = 0
) (
    input  logic [glb_port_pkg::CFG_FLAG_W-1:0] cfg_bank_flag_i,
    input  logic [glb_port_pkg::CFG_PAR_W-1:0]  cfg_par_i,
    input  logic [glb_port_pkg::ADDR_WIDTH-1:0] addr_i,
    output logic                                alloc_o,
    output logic [glb_geom_pkg::BANK_IDX_W-1:0] beat_bank_o,
    output logic [glb_geom_pkg::ROW_W-1:0]      row_o,
    output logic [glb_port_pkg::ADDR_WIDTH-1:0] space_o,
    output logic [glb_geom_pkg::NUM_BANK-1:0]   hit_bank_o
);
    import glb_geom_pkg::*;
    import glb_port_pkg::*;

    logic [NUM_BANK-1:0]   flags;
    logic [PAR_W-1:0]      par;
    logic [BANK_IDX_W-1:0] first;
    logic [BANK_CNT_W-1:0] nbank;
    logic [ADDR_WIDTH-1:0] span;
    logic [ADDR_WIDTH-1:0] group;
    // Kept wide so a group past the last bank does not wrap around
    logic [ADDR_WIDTH-1:0] beat_first;

    assign flags   = cfg_bank_flag_i[FLAG_OFFSET*NUM_BANK +: NUM_BANK];
    assign par     = cfg_par_i[FLAG_OFFSET*PAR_W +: PAR_W];
    assign alloc_o = |flags;

    // Lowest set flag and number of set flags
    always_comb begin
        first = '0;
        nbank = '0;
        for (int i = NUM_BANK - 1; i >= 0; i--) begin
            if (flags[i]) begin
                first = BANK_IDX_W'(i);
            end
            nbank = nbank + BANK_CNT_W'(flags[i]);
        end
    end

    // Lines the port holds before wrapping: SRAM_WORD * nbank / par
    assign span    = ADDR_WIDTH'(nbank) << ROW_W;
    assign space_o = (alloc_o && par != '0) ? span / ADDR_WIDTH'(par)
                                            : ADDR_WIDTH'(SRAM_WORD);

    assign group       = (addr_i % space_o) >> ROW_W;
    assign beat_first  = ADDR_WIDTH'(first) + group * ADDR_WIDTH'(par);
    assign beat_bank_o = beat_first[BANK_IDX_W-1:0];
    assign row_o       = addr_i[ROW_W-1:0];

    // par consecutive banks from the beat's first bank
    always_comb begin
        for (int i = 0; i < NUM_BANK; i++) begin
            hit_bank_o[i] = alloc_o && (ADDR_WIDTH'(i) >= beat_first)
                            && (ADDR_WIDTH'(i) < beat_first + ADDR_WIDTH'(par));
        end
    end

endmodule

/* rtl/glb_port_pkg.sv */
package glb_port_pkg;

    // ======================================================================
    // Port counts and beat format
    // ======================================================================

    localparam int NUM_WRPORT = 2;
    localparam int NUM_RDPORT = 2;
    localparam int NUM_PORT   = NUM_WRPORT + NUM_RDPORT;

    localparam int MAXPAR     = 4;
    localparam int PAR_W      = $clog2(MAXPAR) + 1;
    localparam int ADDR_WIDTH = 8;
    localparam int BEAT_W     = glb_geom_pkg::SRAM_WIDTH * MAXPAR;

    localparam int WRPORT_IDX_W = (NUM_WRPORT > 1) ? $clog2(NUM_WRPORT) : 1;
    localparam int RDPORT_IDX_W = (NUM_RDPORT > 1) ? $clog2(NUM_RDPORT) : 1;

    // ======================================================================
    // Configuration layout
    // ======================================================================

    // Slot p owns flags [p*NUM_BANK +: NUM_BANK] and par [p*PAR_W +: PAR_W]
    // Write ports take the low slots, read ports follow
    localparam int CFG_FLAG_W = glb_geom_pkg::NUM_BANK * NUM_PORT;
    localparam int CFG_PAR_W  = PAR_W * NUM_PORT;

endpackage

/* rtl/glb_ram_hs.sv */
`timescale 1ns/1ps

module glb_ram_hs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                wvalid_i,
    output logic                                wready_o,
    input  logic [glb_geom_pkg::ROW_W-1:0]      waddr_i,
    input  logic [glb_geom_pkg::SRAM_WIDTH-1:0] wdata_i,
    input  logic                                arvalid_i,
    output logic                                arready_o,
    input  logic [glb_geom_pkg::ROW_W-1:0]      araddr_i,
    output logic                                rvalid_o,
    input  logic                                rready_i,
    output logic [glb_geom_pkg::SRAM_WIDTH-1:0] rdata_o
);
    import glb_geom_pkg::*;

    logic [SRAM_WIDTH-1:0] mem [SRAM_WORD];
    logic                  rd_fire;

    // Write side never stalls
    assign wready_o  = 1'b1;
    // One read in flight, slot frees in the cycle its data is taken
    assign arready_o = ~(rvalid_o & ~rready_i);
    assign rd_fire   = arvalid_i & arready_o;

    always_ff @(posedge clk) begin
        if (wvalid_i && wready_o) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_o <= mem[araddr_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
        end else if (rd_fire) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

endmodule

/* rtl/glb_rd_ctrl.sv */
`timescale 1ns/1ps

module glb_rd_ctrl #(
    parameter int PORT = 0
) (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  logic [glb_port_pkg::CFG_FLAG_W-1:0]                        cfg_bank_flag_i,
    input  logic [glb_port_pkg::CFG_PAR_W-1:0]                         cfg_par_i,
    input  logic [glb_port_pkg::ADDR_WIDTH-1:0]                        rd_addr_i,
    input  logic                                                       rd_addr_vld_i,
    output logic                                                       rd_addr_rdy_o,
    input  logic [glb_port_pkg::ADDR_WIDTH*glb_geom_pkg::NUM_BANK-1:0] wr_mark_all_i,
    input  logic [glb_geom_pkg::NUM_BANK-1:0]                          arready_all_i,
    input  logic [glb_geom_pkg::NUM_BANK-1:0]                          rvalid_all_i,
    input  logic [glb_geom_pkg::SRAM_WIDTH*glb_geom_pkg::NUM_BANK-1:0] rdata_all_i,
    output logic [glb_geom_pkg::NUM_BANK-1:0]                          bank_en_o,
    output logic [glb_port_pkg::BEAT_W-1:0]                            rd_dat_o,
    output logic                                                       rd_dat_vld_o
);
    import glb_geom_pkg::*;
    import glb_port_pkg::*;

    logic                  alloc;
    logic [BANK_IDX_W-1:0] beat_bank;
    logic [NUM_BANK-1:0]   hit_bank;
    logic [PAR_W-1:0]      par;
    logic [ADDR_WIDTH-1:0] wr_mark;
    logic                  empty;
    logic                  addr_fire;
    logic                  dat_taken;
    // In-flight beat
    logic                  busy_q;
    logic [BANK_IDX_W-1:0] bank_q;
    logic [PAR_W-1:0]      par_q;

    glb_port_map #(
        .FLAG_OFFSET (NUM_WRPORT + PORT)
    ) u_map (
        .cfg_bank_flag_i (cfg_bank_flag_i),
        .cfg_par_i       (cfg_par_i),
        .addr_i          (rd_addr_i),
        .alloc_o         (alloc),
        .beat_bank_o     (beat_bank),
        .row_o           (),
        .space_o         (),
        .hit_bank_o      (hit_bank)
    );

    assign par     = cfg_par_i[(NUM_WRPORT + PORT)*PAR_W +: PAR_W];
    assign wr_mark = wr_mark_all_i[beat_bank*ADDR_WIDTH +: ADDR_WIDTH];
    assign empty   = rd_addr_i >= wr_mark;

    // A pending beat must be taken before the next address goes out
    assign rd_addr_rdy_o = alloc & ~empty & arready_all_i[beat_bank]
                           & (~busy_q | arready_all_i[bank_q]);
    assign addr_fire     = rd_addr_vld_i & rd_addr_rdy_o;
    assign bank_en_o     = {NUM_BANK{addr_fire}} & hit_bank;

    assign rd_dat_vld_o  = busy_q & rvalid_all_i[bank_q];
    // rvalid with arready high at the bank means rready was seen
    assign dat_taken     = rd_dat_vld_o & arready_all_i[bank_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            bank_q <= '0;
            par_q  <= '0;
        end else if (addr_fire) begin
            busy_q <= 1'b1;
            bank_q <= beat_bank;
            par_q  <= par;
        end else if (dat_taken) begin
            busy_q <= 1'b0;
        end
    end

    // Gather par words from consecutive banks, upper words zero
    always_comb begin
        int idx;
        rd_dat_o = '0;
        for (int k = 0; k < MAXPAR; k++) begin
            idx = int'(bank_q) + k;
            if (k < int'(par_q) && idx < NUM_BANK) begin
                rd_dat_o[k*SRAM_WIDTH +: SRAM_WIDTH] =
                    rdata_all_i[idx*SRAM_WIDTH +: SRAM_WIDTH];
            end
        end
    end

endmodule

/* rtl/glb_wr_ctrl.sv */
`timescale 1ns/1ps

module glb_wr_ctrl #(
    parameter int PORT = 0
) (
    input  logic [glb_port_pkg::CFG_FLAG_W-1:0]                        cfg_bank_flag_i,
    input  logic [glb_port_pkg::CFG_PAR_W-1:0]                         cfg_par_i,
    input  logic [glb_port_pkg::ADDR_WIDTH-1:0]                        wr_addr_i,
    input  logic                                                       wr_vld_i,
    output logic                                                       wr_rdy_o,
    input  logic [glb_port_pkg::ADDR_WIDTH*glb_geom_pkg::NUM_BANK-1:0] rd_mark_all_i,
    output logic [glb_geom_pkg::NUM_BANK-1:0]                          bank_en_o
);
    import glb_geom_pkg::*;
    import glb_port_pkg::*;

    logic                  alloc;
    logic [BANK_IDX_W-1:0] beat_bank;
    logic [ADDR_WIDTH-1:0] space;
    logic [NUM_BANK-1:0]   hit_bank;
    logic [ADDR_WIDTH-1:0] rd_mark;
    logic [ADDR_WIDTH-1:0] fill;
    logic                  full;

    glb_port_map #(
        .FLAG_OFFSET (PORT)
    ) u_map (
        .cfg_bank_flag_i (cfg_bank_flag_i),
        .cfg_par_i       (cfg_par_i),
        .addr_i          (wr_addr_i),
        .alloc_o         (alloc),
        .beat_bank_o     (beat_bank),
        .row_o           (),
        .space_o         (space),
        .hit_bank_o      (hit_bank)
    );

    assign rd_mark = rd_mark_all_i[beat_bank*ADDR_WIDTH +: ADDR_WIDTH];

    // Lines ahead of the reader, modulo the address width
    assign fill     = wr_addr_i - rd_mark;
    assign full     = fill >= space;
    assign wr_rdy_o = alloc & ~full;

    assign bank_en_o = {NUM_BANK{wr_vld_i & wr_rdy_o}} & hit_bank;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the glb testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module glb_tb \
    -Mdir obj_dir -o glb_sim -f glb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/glb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0
